/* Bender.yml */
package:
  name: pong_paddles

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pong_pkg.sv
      - rtl/frame_timer.sv
      - rtl/paddle_motion.sv
      - rtl/render_sequencer.sv
      - rtl/box_scanner.sv
      - rtl/pong_paddles_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_pong_paddles.sv

/* list.f */
+incdir+rtl
rtl/pong_pkg.sv
rtl/frame_timer.sv
rtl/paddle_motion.sv
rtl/render_sequencer.sv
rtl/box_scanner.sv
rtl/pong_paddles_top.sv
tests/tb_pong_paddles.sv

/* rtl/box_scanner.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module box_scanner (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      box_start,
	input  wire pong_pkg::point_t    box_origin,
	input  wire pong_pkg::colour_t   box_colour,
	output pong_pkg::pixel_t         pixel,
	output logic                     plot,
	output logic                     box_done
);

	localparam int COL_W = $clog2(`PONG_PADDLE_W);
	localparam int ROW_W = $clog2(`PONG_PADDLE_H);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(`PONG_PADDLE_W - 1);
	localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`PONG_PADDLE_H - 1);

	logic             armed;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic             last;

	assign last = (col == COL_LAST) && (row == ROW_LAST);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			armed <= 1'b0;
			col   <= '0;
			row   <= '0;
		end else if (box_start) begin
			armed <= 1'b1;
			col   <= '0;
			row   <= '0;
		end else if (armed) begin
			// raster order, column inner
			if (col == COL_LAST) begin
				col <= '0;
				if (last) begin
					row   <= '0;
					armed <= 1'b0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// pixel goes out straight from the counters
	always_comb begin
		pixel.pos.x  = box_origin.x + pong_pkg::x_coord_t'(col);
		pixel.pos.y  = box_origin.y + pong_pkg::y_coord_t'(row);
		pixel.colour = box_colour;
		plot         = armed;
		box_done     = armed && last;
	end

endmodule

`default_nettype wire

/* rtl/frame_timer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module frame_timer #(
	parameter int unsigned CLOCKS_PER_FRAME = `PONG_CLOCKS_PER_FRAME
) (
	input  wire  clk,
	input  wire  resetn,
	output logic frame_tick
);

	// wide enough to hold CLOCKS_PER_FRAME - 1
	localparam int CNT_W = (CLOCKS_PER_FRAME > 1) ? $clog2(CLOCKS_PER_FRAME) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLOCKS_PER_FRAME - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count      <= RELOAD;
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			// one frame elapsed
			count      <= RELOAD;
			frame_tick <= 1'b1;
		end else begin
			count      <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/paddle_motion.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module paddle_motion (
	input  wire                clk,
	input  wire                resetn,
	input  wire                frame_tick,
	input  wire                up,
	input  wire                down,
	output pong_pkg::y_coord_t y,
	output pong_pkg::y_coord_t old_y
);

	localparam pong_pkg::y_coord_t STEP = pong_pkg::y_coord_t'(`PONG_STEP);

	pong_pkg::paddle_dir_e dir;
	pong_pkg::paddle_dir_e dir_next;

	// only move if the step keeps the paddle on screen
	always_comb begin
		dir_next = pong_pkg::DIR_STATIONARY;
		if (up && !down && int'(y) >= `PONG_STEP) begin
			dir_next = pong_pkg::DIR_UP;
		end else if (down && !up && int'(y) + `PONG_STEP <= `PONG_Y_MAX) begin
			dir_next = pong_pkg::DIR_DOWN;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			dir <= pong_pkg::DIR_STATIONARY;
		end else begin
			dir <= dir_next;
		end
	end

	// old row is kept for the erase pass
	always_ff @(posedge clk) begin
		if (!resetn) begin
			y     <= pong_pkg::y_coord_t'(`PONG_Y_START);
			old_y <= pong_pkg::y_coord_t'(`PONG_Y_START);
		end else if (frame_tick) begin
			old_y <= y;
			case (dir)
				pong_pkg::DIR_UP: begin
					y <= y - STEP;
				end
				pong_pkg::DIR_DOWN: begin
					y <= y + STEP;
				end
				default: begin
					y <= y;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/pong_config.svh */
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

// screen geometry
`define PONG_SCREEN_W 320
`define PONG_SCREEN_H 240

// paddle geometry and placement
`define PONG_PADDLE_W 5
`define PONG_PADDLE_H 40
`define PONG_PADDLE1_X (`PONG_SCREEN_W / 32)
`define PONG_PADDLE2_X (`PONG_SCREEN_W - `PONG_PADDLE_W)
`define PONG_Y_START (`PONG_SCREEN_H / 2)
`define PONG_Y_MAX (`PONG_SCREEN_H - 1 - `PONG_PADDLE_H)
`define PONG_STEP 1

// 50 MHz clock, 15 frames per second
`define PONG_CLOCKS_PER_FRAME (50000000 / 15)

`define PONG_COLOUR_BG 0
`define PONG_COLOUR_PADDLE 7

`endif

/* rtl/pong_paddles_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module pong_paddles_top #(
	parameter int unsigned CLOCKS_PER_FRAME = `PONG_CLOCKS_PER_FRAME
) (
	input  wire              clk,
	input  wire              resetn,
	input  wire              up_1,
	input  wire              down_1,
	input  wire              up_2,
	input  wire              down_2,
	output pong_pkg::pixel_t pixel,
	output logic             plot
);

	logic              frame_tick;
	pong_pkg::y_coord_t y_1;
	pong_pkg::y_coord_t old_y_1;
	pong_pkg::y_coord_t y_2;
	pong_pkg::y_coord_t old_y_2;
	logic              box_start;
	logic              box_done;
	pong_pkg::point_t  box_origin;
	pong_pkg::colour_t box_colour;

	frame_timer #(
		.CLOCKS_PER_FRAME(CLOCKS_PER_FRAME)
	) timer (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick)
	);

	// left paddle
	paddle_motion paddle_1 (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick),
		.up        (up_1),
		.down      (down_1),
		.y         (y_1),
		.old_y     (old_y_1)
	);

	// right paddle
	paddle_motion paddle_2 (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick),
		.up        (up_2),
		.down      (down_2),
		.y         (y_2),
		.old_y     (old_y_2)
	);

	render_sequencer sequencer (
		.clk       (clk),
		.resetn    (resetn),
		.frame_tick(frame_tick),
		.y_1       (y_1),
		.old_y_1   (old_y_1),
		.y_2       (y_2),
		.old_y_2   (old_y_2),
		.box_done  (box_done),
		.box_start (box_start),
		.box_origin(box_origin),
		.box_colour(box_colour)
	);

	box_scanner scanner (
		.clk       (clk),
		.resetn    (resetn),
		.box_start (box_start),
		.box_origin(box_origin),
		.box_colour(box_colour),
		.pixel     (pixel),
		.plot      (plot),
		.box_done  (box_done)
	);

endmodule

`default_nettype wire

/* rtl/pong_pkg.sv */
`default_nettype none
`include "pong_config.svh"

package pong_pkg;

	// screen coordinates, sized from the screen dimensions
	typedef logic [$clog2(`PONG_SCREEN_W)-1:0] x_coord_t;
	typedef logic [$clog2(`PONG_SCREEN_H)-1:0] y_coord_t;
	typedef logic [2:0] colour_t;

	typedef struct packed {
		x_coord_t x;
		y_coord_t y;
	} point_t;

	// one pixel as seen by the VGA side
	typedef struct packed {
		point_t  pos;
		colour_t colour;
	} pixel_t;

	typedef enum logic [1:0] {
		DIR_STATIONARY,
		DIR_UP,
		DIR_DOWN
	} paddle_dir_e;

	// erase then redraw, paddle 1 before paddle 2
	typedef enum logic [2:0] {
		RS_IDLE,
		RS_CLEAR_1,
		RS_DRAW_1,
		RS_CLEAR_2,
		RS_DRAW_2
	} render_state_e;

endpackage

`default_nettype wire

/* rtl/render_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module render_sequencer (
	input  wire                     clk,
	input  wire                     resetn,
	input  wire                     frame_tick,
	input  wire pong_pkg::y_coord_t y_1,
	input  wire pong_pkg::y_coord_t old_y_1,
	input  wire pong_pkg::y_coord_t y_2,
	input  wire pong_pkg::y_coord_t old_y_2,
	input  wire                     box_done,
	output logic                    box_start,
	output pong_pkg::point_t        box_origin,
	output pong_pkg::colour_t       box_colour
);

	localparam pong_pkg::x_coord_t X_1 = pong_pkg::x_coord_t'(`PONG_PADDLE1_X);
	localparam pong_pkg::x_coord_t X_2 = pong_pkg::x_coord_t'(`PONG_PADDLE2_X);
	localparam pong_pkg::colour_t  BG  = pong_pkg::colour_t'(`PONG_COLOUR_BG);
	localparam pong_pkg::colour_t  FG  = pong_pkg::colour_t'(`PONG_COLOUR_PADDLE);

	pong_pkg::render_state_e state;

	// a tick only starts a render from idle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= pong_pkg::RS_IDLE;
			box_start <= 1'b0;
		end else begin
			box_start <= 1'b0;
			case (state)
				pong_pkg::RS_IDLE: begin
					if (frame_tick) begin
						state     <= pong_pkg::RS_CLEAR_1;
						box_start <= 1'b1;
					end
				end
				pong_pkg::RS_CLEAR_1: begin
					if (box_done) begin
						state     <= pong_pkg::RS_DRAW_1;
						box_start <= 1'b1;
					end
				end
				pong_pkg::RS_DRAW_1: begin
					if (box_done) begin
						state     <= pong_pkg::RS_CLEAR_2;
						box_start <= 1'b1;
					end
				end
				pong_pkg::RS_CLEAR_2: begin
					if (box_done) begin
						state     <= pong_pkg::RS_DRAW_2;
						box_start <= 1'b1;
					end
				end
				pong_pkg::RS_DRAW_2: begin
					if (box_done) begin
						state <= pong_pkg::RS_IDLE;
					end
				end
				default: begin
					state <= pong_pkg::RS_IDLE;
				end
			endcase
		end
	end

	// origin follows the pass, rows only change on a tick
	always_comb begin
		case (state)
			pong_pkg::RS_DRAW_1: begin
				box_origin.x = X_1;
				box_origin.y = y_1;
				box_colour   = FG;
			end
			pong_pkg::RS_CLEAR_2: begin
				box_origin.x = X_2;
				box_origin.y = old_y_2;
				box_colour   = BG;
			end
			pong_pkg::RS_DRAW_2: begin
				box_origin.x = X_2;
				box_origin.y = y_2;
				box_colour   = FG;
			end
			default: begin
				box_origin.x = X_1;
				box_origin.y = old_y_1;
				box_colour   = BG;
			end
		endcase
	end

endmodule

`default_nettype wire

/* tests/tb_pong_paddles.sv */
`timescale 1ns/10ps
`default_nettype none
`include "pong_config.svh"

module tb_pong_paddles;

	localparam int FRAME_CLOCKS   = 1000;
	localparam int NUM_ROWS       = 6;
	localparam int BOX_PIXELS     = `PONG_PADDLE_W * `PONG_PADDLE_H;
	localparam int FRAME_PIXELS   = 4 * BOX_PIXELS;
	localparam int CAPTURE_CYCLES = FRAME_PIXELS + 20;
	localparam int MAX_SHOWN      = 20;

	// buttons held for a number of frames
	typedef struct packed {
		logic        up_1;
		logic        down_1;
		logic        up_2;
		logic        down_2;
		logic [15:0] frames;
	} stim_row_t;

	logic             clk;
	logic             resetn;
	logic             up_1;
	logic             down_1;
	logic             up_2;
	logic             down_2;
	pong_pkg::pixel_t pixel;
	logic             plot;

	stim_row_t        stim_table [NUM_ROWS];
	pong_pkg::pixel_t captured [FRAME_PIXELS];
	int               captured_count;
	int               checks;
	int               errors;
	int               shown;
	int               timeout_limit;
	int               cycle_count;
	int               model_y_1;
	int               model_old_1;
	int               model_y_2;
	int               model_old_2;

	pong_paddles_top #(
		.CLOCKS_PER_FRAME(FRAME_CLOCKS)
	) uut (
		.clk   (clk),
		.resetn(resetn),
		.up_1  (up_1),
		.down_1(down_1),
		.up_2  (up_2),
		.down_2(down_2),
		.pixel (pixel),
		.plot  (plot)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// columns: up_1, down_1, up_2, down_2, frames
	task automatic fill_table();
		stim_table[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 16'd2};
		stim_table[1] = '{1'b1, 1'b0, 1'b0, 1'b1, 16'd5};
		stim_table[2] = '{1'b1, 1'b1, 1'b1, 1'b1, 16'd3};
		// long enough to pin both paddles at the edges
		stim_table[3] = '{1'b1, 1'b0, 1'b0, 1'b1, 16'd125};
		stim_table[4] = '{1'b0, 1'b1, 1'b1, 1'b0, 16'd210};
		stim_table[5] = '{1'b0, 1'b0, 1'b0, 1'b0, 16'd3};
	endtask

	function automatic int total_frames();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			sum += int'(stim_table[i].frames);
		end
		return sum;
	endfunction

	task automatic drive_buttons(input stim_row_t row);
		up_1   <= row.up_1;
		down_1 <= row.down_1;
		up_2   <= row.up_2;
		down_2 <= row.down_2;
	endtask

	// motion rule for one frame
	function automatic int step_row(input int y, input logic up, input logic down);
		if (up && !down && y >= `PONG_STEP) begin
			return y - `PONG_STEP;
		end else if (down && !up && y + `PONG_STEP <= `PONG_Y_MAX) begin
			return y + `PONG_STEP;
		end
		return y;
	endfunction

	// boxes in order: erase 1, draw 1, erase 2, draw 2
	function automatic pong_pkg::pixel_t expected_pixel(input int index);
		pong_pkg::pixel_t exp;
		int box;
		int k;
		int ox;
		int oy;
		box = index / BOX_PIXELS;
		k   = index % BOX_PIXELS;
		ox  = (box < 2) ? `PONG_PADDLE1_X : `PONG_PADDLE2_X;
		case (box)
			0: oy = model_old_1;
			1: oy = model_y_1;
			2: oy = model_old_2;
			default: oy = model_y_2;
		endcase
		exp.pos.x  = pong_pkg::x_coord_t'(ox + k % `PONG_PADDLE_W);
		exp.pos.y  = pong_pkg::y_coord_t'(oy + k / `PONG_PADDLE_W);
		exp.colour = (box % 2 == 0) ? pong_pkg::colour_t'(`PONG_COLOUR_BG)
			: pong_pkg::colour_t'(`PONG_COLOUR_PADDLE);
		return exp;
	endfunction

	// wait for the first plotted pixel, then gather the whole render
	task automatic capture_frame(output bit found, output int waited);
		found          = 1'b0;
		waited         = 0;
		captured_count = 0;
		while (!found && waited < 2 * FRAME_CLOCKS) begin
			@(negedge clk);
			if (plot === 1'b1) begin
				found = 1'b1;
			end else begin
				waited++;
			end
		end
		if (found) begin
			for (int i = 0; i < CAPTURE_CYCLES; i++) begin
				if (i > 0) begin
					@(negedge clk);
				end
				if (plot === 1'b1) begin
					if (captured_count < FRAME_PIXELS) begin
						captured[captured_count] = pixel;
					end
					captured_count++;
				end
			end
		end
	endtask

	task automatic check_frame();
		pong_pkg::pixel_t exp;
		int limit;
		checks++;
		assert (captured_count == FRAME_PIXELS) else begin
			$display("CHECK FAILED plot count: got 0x%0h expected 0x%0h",
				captured_count, FRAME_PIXELS);
			errors++;
		end
		limit = (captured_count < FRAME_PIXELS) ? captured_count : FRAME_PIXELS;
		for (int i = 0; i < limit; i++) begin
			exp = expected_pixel(i);
			checks++;
			assert (captured[i] === exp) else begin
				errors++;
				if (shown < MAX_SHOWN) begin
					$display("CHECK FAILED pixel[%0d]: got 0x%05h expected 0x%05h",
						i, captured[i], exp);
				end
				shown++;
			end
		end
	endtask

	initial begin : stimulus
		bit found;
		int waited;
		bit first;
		bit aborted;
		int row_errors;
		resetn   = 1'b0;
		up_1     = 1'b0;
		down_1   = 1'b0;
		up_2     = 1'b0;
		down_2   = 1'b0;
		checks   = 0;
		errors   = 0;
		shown    = 0;
		first    = 1'b1;
		aborted  = 1'b0;
		fill_table();
		timeout_limit = total_frames() * FRAME_CLOCKS + 2000;
		model_y_1   = `PONG_Y_START;
		model_old_1 = `PONG_Y_START;
		model_y_2   = `PONG_Y_START;
		model_old_2 = `PONG_Y_START;

		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		drive_buttons(stim_table[0]);

		for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
			row_errors = errors;
			for (int f = 0; f < int'(stim_table[r].frames) && !aborted; f++) begin
				model_old_1 = model_y_1;
				model_old_2 = model_y_2;
				model_y_1 = step_row(model_y_1, stim_table[r].up_1, stim_table[r].down_1);
				model_y_2 = step_row(model_y_2, stim_table[r].up_2, stim_table[r].down_2);
				capture_frame(found, waited);
				if (!found) begin
					$display("no plotted pixels seen in row %0d frame %0d, giving up", r, f);
					errors++;
					aborted = 1'b1;
				end else begin
					if (first) begin
						checks++;
						assert (waited >= FRAME_CLOCKS) else begin
							$display("plot went high after %0d cycles, before the first frame",
								waited);
							errors++;
						end
						first = 1'b0;
					end
					check_frame();
					// new buttons only once this frame's render is over
					if (f == int'(stim_table[r].frames) - 1 && r + 1 < NUM_ROWS) begin
						@(posedge clk);
						drive_buttons(stim_table[r + 1]);
					end
				end
			end
			$display("row %0d: %0d frames, rows %0d/%0d, %0d errors", r,
				stim_table[r].frames, model_y_1, model_y_2, errors - row_errors);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
